// File: source/maUnit_macros.svh
`ifndef MA_UNIT_MACROS_SVH
`define MA_UNIT_MACROS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Operand and result word
`define MA_DATA_WIDTH 32

// Issue tag, one per operation in flight
`define MA_TAG_WIDTH 4

////////////////////////////////////////
// Pipeline depths
////////////////////////////////////////

`define MA_MLT_DEPTH 3 // Multiplier stages
`define MA_ADD_DEPTH 1 // Adder stages

// Third operands waiting for their products
// Must cover every multiply-add inside the multiplier
`define MA_BUFF_DEPTH 4

`endif

// File: source/maDataPkg.sv
`include "maUnit_macros.svh"

////////////////////////////////////////
// Data types of the multiply-add unit
////////////////////////////////////////

package maDataPkg;

	// One operand or result word
	typedef logic [`MA_DATA_WIDTH-1:0] dataT;

	// Identity of an issued operation
	// Results leave out of order, so the tag is what pairs them up
	typedef logic [`MA_TAG_WIDTH-1:0] tagT;

	// Low word of a full product, wraps modulo 2^32
	function automatic dataT lowProduct(input dataT x, input dataT y);
		logic [2*`MA_DATA_WIDTH-1:0] full;
		full = x * y;
		return full[`MA_DATA_WIDTH-1:0];
	endfunction

endpackage

// File: source/maOpPkg.sv
////////////////////////////////////////
// Operation encoding
////////////////////////////////////////

package maOpPkg;

	typedef logic [1:0] opT;

	localparam opT opAdd = 2'd0; // a + b
	localparam opT opMul = 2'd1; // a * b
	localparam opT opMad = 2'd2; // a * b + c
	// 2'd3 is reserved and never issued

	// True for operations that go through the multiplier
	function automatic logic usesMlt(input opT code);
		return (code == opMul) || (code == opMad);
	endfunction

	// True when the third operand is needed
	function automatic logic usesThird(input opT code);
		return code == opMad;
	endfunction

endpackage

// File: source/productIf.sv
`timescale 1ns/1ps

////////////////////////////////////////
// Multiplier result into the adder
////////////////////////////////////////

interface productIf;
	import maDataPkg::*;
	import maOpPkg::*;

	logic valid; // Also the issue stall
	opT op;      // opMul or opMad only
	tagT tag;
	dataT data;  // Low word of a*b

	modport source (
		output valid,
		output op,
		output tag,
		output data
	);

	modport sink (
		input valid,
		input op,
		input tag,
		input data
	);

endinterface

// File: source/operandBuffIf.sv
`timescale 1ns/1ps

////////////////////////////////////////
// Third operand ring buffer access
////////////////////////////////////////

interface operandBuffIf;
	import maDataPkg::*;

	logic write;     // One pulse per accepted multiply-add
	dataT writeData;
	logic read;      // Pops the oldest entry
	dataT readData;  // Oldest entry, valid in the read cycle

	modport writer (
		output write,
		output writeData
	);

	modport reader (
		output read,
		input readData
	);

	modport memory (
		input write,
		input writeData,
		input read,
		output readData
	);

endinterface

// File: source/mltPipe.sv
`timescale 1ns/1ps
`include "maUnit_macros.svh"

module mltPipe #(
	parameter int mltDepth = `MA_MLT_DEPTH
)(
	input logic clock,
	input logic rst,
	input logic issue,
	input maOpPkg::opT op,
	input maDataPkg::tagT tag,
	input maDataPkg::dataT a,
	input maDataPkg::dataT b,
	input maDataPkg::dataT c,
	productIf.source prod,
	operandBuffIf.writer buff
);
	import maDataPkg::*;
	import maOpPkg::*;

	logic accept;

	// One entry per stage, index 0 is the first
	logic validQ [mltDepth];
	opT opQ [mltDepth];
	tagT tagQ [mltDepth];
	dataT dataQ [mltDepth];

	assign accept = issue && usesMlt(op);

	// Third operand parks in the buffer until the product is out
	assign buff.write = accept && usesThird(op);
	assign buff.writeData = c;

	////////////////////////////////////////
	// Stage chain
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < mltDepth; i++) begin
				validQ[i] <= 1'b0;
			end
		end else begin
			validQ[0] <= accept;
			for (int i = 1; i < mltDepth; i++) begin
				validQ[i] <= validQ[i-1];
			end
		end
	end

	// Product is formed in the first stage, later stages only carry it
	always_ff @(posedge clock) begin
		opQ[0] <= op;
		tagQ[0] <= tag;
		dataQ[0] <= lowProduct(a, b);
		for (int i = 1; i < mltDepth; i++) begin
			opQ[i] <= opQ[i-1];
			tagQ[i] <= tagQ[i-1];
			dataQ[i] <= dataQ[i-1];
		end
	end

	assign prod.valid = validQ[mltDepth-1];
	assign prod.op = opQ[mltDepth-1];
	assign prod.tag = tagQ[mltDepth-1];
	assign prod.data = dataQ[mltDepth-1];

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// An add must never reach the adder by way of the multiplier
	for (genvar s = 0; s < mltDepth; s++) begin : gStageCheck
		assert property (@(posedge clock) disable iff (rst)
			validQ[s] |-> (opQ[s] != opAdd))
			else $error("Add found in multiplier stage %0d", s);
	end

endmodule

// File: source/operandRingBuffer.sv
`timescale 1ns/1ps
`include "maUnit_macros.svh"

module operandRingBuffer #(
	parameter int depth = `MA_BUFF_DEPTH
)(
	input logic clock,
	input logic rst,
	operandBuffIf.memory port
);
	import maDataPkg::*;

	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntWidth = $clog2(depth + 1);

	dataT mem [depth];

	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] count; // Entries held
	logic full;
	logic empty;

	// Pointer step that wraps at any depth, not only powers of two
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		return (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = (count == cntWidth'(depth));
	assign empty = (count == '0);

	// Oldest entry is always on the read port
	assign port.readData = mem[rdPtr];

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (port.write) begin
			mem[wrPtr] <= port.writeData;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (port.write) wrPtr <= nextPtr(wrPtr);
			if (port.read) rdPtr <= nextPtr(rdPtr);
			case ({port.write, port.read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Push and pop together
			endcase
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Depth too small for the multiplier if this fires
	assert property (@(posedge clock) disable iff (rst) port.write |-> !full)
		else $error("Operand buffer written while full");

	// A multiply-add product arrived without its operand
	assert property (@(posedge clock) disable iff (rst) port.read |-> !empty)
		else $error("Operand buffer read while empty");

endmodule

// File: source/addPipe.sv
`timescale 1ns/1ps
`include "maUnit_macros.svh"

module addPipe #(
	parameter int addDepth = `MA_ADD_DEPTH
)(
	input logic clock,
	input logic rst,
	input logic issue,
	input maOpPkg::opT op,
	input maDataPkg::tagT tag,
	input maDataPkg::dataT a,
	input maDataPkg::dataT b,
	productIf.sink prod,
	operandBuffIf.reader buff,
	output logic resValid,
	output maDataPkg::tagT resTag,
	output maDataPkg::dataT resData
);
	import maDataPkg::*;
	import maOpPkg::*;

	logic isAdd;     // Issued add this cycle
	logic loadValid;
	tagT loadTag;
	dataT addendA;
	dataT addendB;

	logic validQ [addDepth];
	tagT tagQ [addDepth];
	dataT sumQ [addDepth];

	assign isAdd = issue && (op == opAdd);
	assign loadValid = prod.valid || isAdd;

	// Pop the waiting third operand together with its product
	assign buff.read = prod.valid && usesThird(prod.op);

	////////////////////////////////////////
	// Input select
	////////////////////////////////////////

	// Product has priority, the issuer holds adds while it is valid
	always_comb begin
		if (prod.valid) begin
			loadTag = prod.tag;
			addendA = prod.data;
			addendB = usesThird(prod.op) ? buff.readData : '0; // Plain multiply adds zero
		end else begin
			loadTag = tag;
			addendA = a;
			addendB = b;
		end
	end

	////////////////////////////////////////
	// Adder stages
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < addDepth; i++) begin
				validQ[i] <= 1'b0;
			end
		end else begin
			validQ[0] <= loadValid;
			for (int i = 1; i < addDepth; i++) begin
				validQ[i] <= validQ[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		tagQ[0] <= loadTag;
		sumQ[0] <= addendA + addendB; // Wraps modulo 2^32
		for (int i = 1; i < addDepth; i++) begin
			tagQ[i] <= tagQ[i-1];
			sumQ[i] <= sumQ[i-1];
		end
	end

	assign resValid = validQ[addDepth-1];
	assign resTag = tagQ[addDepth-1];
	assign resData = sumQ[addDepth-1];

	// Issuer broke the stall rule and an add would be lost
	assert property (@(posedge clock) disable iff (rst) !(isAdd && prod.valid))
		else $error("Add issued during product stall");

endmodule

// File: source/maUnit.sv
`timescale 1ns/1ps
`include "maUnit_macros.svh"

module maUnit #(
	parameter int mltDepth = `MA_MLT_DEPTH,
	parameter int addDepth = `MA_ADD_DEPTH,
	parameter int buffDepth = `MA_BUFF_DEPTH
)(
	input logic clock,
	input logic rst,
	input logic issue,
	input maOpPkg::opT op,
	input maDataPkg::tagT tag,
	input maDataPkg::dataT a,
	input maDataPkg::dataT b,
	input maDataPkg::dataT c,
	output logic stall,
	output logic resValid,
	output maDataPkg::tagT resTag,
	output maDataPkg::dataT resData
);

	productIf prodBus ();
	operandBuffIf buffBus ();

	// A product entering the adder blocks any issued add
	assign stall = prodBus.valid;

	////////////////////////////////////////
	// Multiplier, buffer, adder
	////////////////////////////////////////

	mltPipe #(
		.mltDepth (mltDepth)
	) mltPipe0 (
		.clock (clock),
		.rst   (rst),
		.issue (issue),
		.op    (op),
		.tag   (tag),
		.a     (a),
		.b     (b),
		.c     (c),
		.prod  (prodBus.source),
		.buff  (buffBus.writer)
	);

	operandRingBuffer #(
		.depth (buffDepth)
	) operandRingBuffer0 (
		.clock (clock),
		.rst   (rst),
		.port  (buffBus.memory)
	);

	addPipe #(
		.addDepth (addDepth)
	) addPipe0 (
		.clock    (clock),
		.rst      (rst),
		.issue    (issue),
		.op       (op),
		.tag      (tag),
		.a        (a),
		.b        (b),
		.prod     (prodBus.sink),
		.buff     (buffBus.reader),
		.resValid (resValid),
		.resTag   (resTag),
		.resData  (resData)
	);

endmodule

// File: sim/maUnitTb.sv
`timescale 1ns/1ps
`include "maUnit_macros.svh"

module maUnitTb;
	import maDataPkg::*;
	import maOpPkg::*;

	localparam int addLat = `MA_ADD_DEPTH;
	localparam int mltLat = `MA_MLT_DEPTH + `MA_ADD_DEPTH;
	localparam int tagCount = 1 << `MA_TAG_WIDTH;
	localparam int randCount = 200;
	localparam int totalIssues = 9 + 1 + 6 + randCount;
	localparam int clockPeriod = 4;
	// Every issue could wait out a full multiply, plus reset and idle time
	localparam int timeoutNs = (totalIssues * mltLat + 100) * clockPeriod;

	logic clock = 1'b0;
	logic rst = 1'b1;
	logic issue = 1'b0;
	opT op = opAdd;
	tagT tag = '0;
	dataT a = '0;
	dataT b = '0;
	dataT c = '0;
	logic stall;
	logic resValid;
	tagT resTag;
	dataT resData;

	int cycleCount = 0;   // Rising edges so far
	int pendingCount = 0;
	logic pending [tagCount];
	dataT expData [tagCount];
	int expEdge [tagCount]; // Edge where resValid must be seen
	tagT nextTag = '0;
	logic [31:0] lfsrState = 32'd54;

	maUnit dut0 (
		.clock    (clock),
		.rst      (rst),
		.issue    (issue),
		.op       (op),
		.tag      (tag),
		.a        (a),
		.b        (b),
		.c        (c),
		.stall    (stall),
		.resValid (resValid),
		.resTag   (resTag),
		.resData  (resData)
	);

	always #(clockPeriod / 2) clock = ~clock;

	always @(posedge clock) cycleCount <= cycleCount + 1;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003; // Taps 32, 22, 2, 1
		end
		return state >> 1;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	// Reference result, wraps modulo 2^32
	function automatic dataT expectedResult(input opT code, input dataT x, input dataT y,
		input dataT z);
		logic [63:0] full;
		full = 64'(x) * 64'(y);
		case (code)
			opAdd: return x + y;
			opMul: return full[31:0];
			default: return full[31:0] + z;
		endcase
	endfunction

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			stopOnError($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// Drives one issue and records what must come back
	task automatic driveIssue(input opT code, input dataT x, input dataT y, input dataT z);
		tagT t;
		t = nextTag;
		if (pending[t]) begin
			stopOnError($sformatf("Tag %0d reused while still in flight", t));
		end
		nextTag = nextTag + tagT'(1);
		pending[t] = 1'b1;
		pendingCount++;
		expData[t] = expectedResult(code, x, y, z);
		expEdge[t] = cycleCount + 1 + ((code == opAdd) ? addLat : mltLat);
		issue = 1'b1;
		op = code;
		tag = t;
		a = x;
		b = y;
		c = z;
		@(negedge clock);
	endtask

	task automatic driveIdle();
		issue = 1'b0;
		@(negedge clock);
	endtask

	task automatic drainAll();
		while (pendingCount != 0) begin
			driveIdle();
		end
	endtask

	// Every result is matched by tag
	always @(negedge clock) begin
		if (!rst && resValid) begin
			if (!pending[resTag]) begin
				stopOnError($sformatf("Result arrived for tag %0d with nothing outstanding",
					resTag));
			end else begin
				checkValue("resData", 64'(resData), 64'(expData[resTag]));
				checkValue("resValid edge", 64'(cycleCount + 1), 64'(expEdge[resTag]));
				pending[resTag] = 1'b0;
				pendingCount--;
			end
		end
	end

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic checkIdleAfterReset();
		for (int i = 0; i < 10; i++) begin
			checkValue("stall", 64'(stall), 64'(0));
			checkValue("resValid", 64'(resValid), 64'(0));
			driveIdle();
		end
	endtask

	task automatic runAdds();
		driveIssue(opAdd, randBits(32), randBits(32), '0); // Lone add
		drainAll();
		for (int i = 0; i < 8; i++) begin
			driveIssue(opAdd, randBits(32), randBits(32), '0);
		end
		drainAll();
	endtask

	task automatic runLoneMul();
		int issueEdge;
		int stallCount;
		int stallEdge;
		issueEdge = cycleCount + 1;
		stallCount = 0;
		stallEdge = 0;
		driveIssue(opMul, randBits(32), randBits(32), '0);
		while (pendingCount != 0) begin
			if (stall) begin
				stallCount++;
				stallEdge = cycleCount + 1;
			end
			driveIdle();
		end
		checkValue("stall cycles", 64'(stallCount), 64'(1));
		checkValue("stall edge", 64'(stallEdge), 64'(issueEdge + `MA_MLT_DEPTH));
	endtask

	task automatic runMadBurst();
		logic [31:0] third;
		for (int i = 0; i < 6; i++) begin
			third = {28'(randBits(28)), 4'(i)}; // Low bits keep c distinct
			driveIssue(opMad, randBits(32), randBits(32), third);
		end
		drainAll();
	endtask

	task automatic runRandomMix();
		opT code;
		dataT x;
		dataT y;
		dataT z;
		for (int i = 0; i < randCount; i++) begin
			if (randBits(2) == 0) begin
				driveIdle();
			end
			code = opT'(randBits(2) % 3);
			while (code == opAdd && stall) begin
				driveIdle(); // Adds wait out the product
			end
			x = randBits(32);
			y = randBits(32);
			z = randBits(32);
			driveIssue(code, x, y, z);
		end
		drainAll();
	endtask

	initial begin
		#(timeoutNs);
		stopOnError("Watchdog expired before the tests finished");
	end

	initial begin
		for (int i = 0; i < tagCount; i++) begin
			pending[i] = 1'b0;
		end
		repeat (5) @(negedge clock);
		rst = 1'b0;
		checkIdleAfterReset();
		runAdds();
		runLoneMul();
		runMadBurst();
		runRandomMix();
		if (pendingCount != 0) begin
			stopOnError("Operations still outstanding at the end of the tests");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: list.f
+incdir+source
source/maDataPkg.sv
source/maOpPkg.sv
source/productIf.sv
source/operandBuffIf.sv
source/mltPipe.sv
source/operandRingBuffer.sv
source/addPipe.sv
source/maUnit.sv
sim/maUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the multiply-add unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module maUnitTb -o maUnitSim \
	&& simOut="$(./obj_dir/maUnitSim 2>&1)"
status=$?
echo "${simOut}"

[ "${status}" -eq 0 ] && grep -q "TEST RESULT: PASS" <<< "${simOut}" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
